// ==== mips_core.f ====
+incdir+.
mips_core_pkg.sv
instr_memory.sv
control_decoder.sv
register_file.sv
alu_execute.sv
core_control.sv
mips_core.sv
tb_mips_core.sv

// ==== Makefile ====
# Verilator flow for the MIPS core testbench

TOP = tb_mips_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f mips_core.f --top-module $(TOP) -o $(TOP)

# Pass only when the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

// ==== tb_mips_core.sv ====
`include "mips_core_consts.svh"

module tb_mips_core
    import mips_core_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    // Whole run needs about 2000 cycles, limit leaves a wide margin
    localparam int MAX_CYCLES  = 20000;
    localparam int MODEL_STEPS = 1000;
    localparam int SETTLE      = 1;

    logic     i_clk = 1'b0;
    logic     rst_n;
    apb_req_t apb;
    apb_rsp_t apb_rsp;

    // Program image and reference state
    word_t prog [`IMEM_WORDS];
    word_t model_regs [`NUM_REGS];
    word_t exp_pc;
    word_t exp_status;
    word_t wr_words [`IMEM_WORDS];

    // Stimulus scratch
    integer seed = 32'hc6ca9294;
    word_t  rnd;
    word_t  rd_word;
    logic   rd_err;
    word_t  cmp_word;

    int cycles = 0;
    int checks = 0;
    int errors = 0;

    event check_start;
    event check_done;

    mips_core mips_core_inst
    (
        .i_clk   (i_clk),
        .rst_n   (rst_n),
        .apb     (apb),
        .apb_rsp (apb_rsp)
    );

    // 20 ns clock
    always #10 i_clk = ~i_clk;

    //////////////////////////////////////////////////////////////////////
    // Checking and reporting
    //////////////////////////////////////////////////////////////////////

    task automatic check_word(input word_t got, input word_t exp, input string what);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_counts();
        $display("Checks: %0d, errors: %0d", checks, errors);
    endtask

    // Run limit
    always @(posedge i_clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            report_counts();
            $display("Some tests failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // APB host
    //////////////////////////////////////////////////////////////////////

    task automatic apb_access(input logic write, input logic [`APB_AW-1:0] addr,
                              input word_t wdata, output word_t rdata, output logic err);
        // Setup phase
        @(negedge i_clk);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = write;
        apb.paddr   = addr;
        apb.pwdata  = wdata;
        // Access phase, response sampled well before the access edge
        @(negedge i_clk);
        apb.penable = 1'b1;
        #SETTLE;
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check_word(word_t'(apb_rsp.pready), 32'd1, "pready");
        @(posedge i_clk);
        // Back to idle
        @(negedge i_clk);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [`APB_AW-1:0] addr, input word_t data,
                             input logic exp_err);
        word_t rdata;
        logic  err;
        apb_access(1'b1, addr, data, rdata, err);
        check_word(word_t'(err), word_t'(exp_err), $sformatf("pslverr of write to %h", addr));
    endtask

    task automatic apb_read(input logic [`APB_AW-1:0] addr, output word_t data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        check_word(word_t'(err), '0, $sformatf("pslverr of read from %h", addr));
    endtask

    function automatic logic [`APB_AW-1:0] imem_byte_addr(input int index);
        return `ADDR_IMEM_BASE + `APB_AW'(4 * index);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Instruction encoding
    //////////////////////////////////////////////////////////////////////

    function automatic word_t enc_r(input funct_t fn, input reg_addr_t rs, input reg_addr_t rt,
                                    input reg_addr_t rd, input logic [4:0] shamt);
        return {`OP_RTYPE, rs, rt, rd, shamt, fn};
    endfunction

    function automatic word_t enc_i(input opcode_t op, input reg_addr_t rs, input reg_addr_t rt,
                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // One of the nine R-type operations
    function automatic funct_t pick_funct(input logic [3:0] k);
        case (k)
            4'd0:    return `FN_ADD;
            4'd1:    return `FN_SUB;
            4'd2:    return `FN_SUBU;
            4'd3:    return `FN_AND;
            4'd4:    return `FN_OR;
            4'd5:    return `FN_NOR;
            4'd6:    return `FN_XOR;
            4'd7:    return `FN_SLT;
            default: return `FN_SLL;
        endcase
    endfunction

    function automatic opcode_t pick_imm_op(input int k);
        case (k)
            0:       return `OP_ADDI;
            1:       return `OP_ORI;
            default: return `OP_SLTI;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Runs prog from address 0 to the halt word on model_regs, gives the final PC
    function automatic word_t run_reference();
        word_t     pc;
        word_t     next_pc;
        word_t     ins;
        word_t     a;
        word_t     b;
        word_t     imm_s;
        word_t     res;
        logic      wr;
        reg_addr_t dst;
        pc = '0;
        for (int step = 0; step < MODEL_STEPS; step++)
        begin
            ins = prog[pc[`IMEM_AW+1:2]];
            if (ins == `HALT_WORD)
            begin
                break;
            end
            a       = model_regs[ins[25:21]];
            b       = model_regs[ins[20:16]];
            imm_s   = {{16{ins[15]}}, ins[15:0]};
            wr      = 1'b1;
            dst     = ins[20:16];
            res     = '0;
            next_pc = pc + 4;
            case (ins[31:26])
                `OP_RTYPE:
                begin
                    dst = ins[15:11];
                    case (ins[5:0])
                        `FN_ADD:           res = a + b;
                        `FN_SUB, `FN_SUBU: res = a - b;
                        `FN_AND:           res = a & b;
                        `FN_OR:            res = a | b;
                        `FN_NOR:           res = ~(a | b);
                        `FN_XOR:           res = a ^ b;
                        `FN_SLT:           res = {31'b0, $signed(a) < $signed(b)};
                        `FN_SLL:           res = b << ins[10:6];
                        default:           wr = 1'b0;
                    endcase
                end
                `OP_ADDI: res = a + imm_s;
                `OP_ORI:  res = a | {16'b0, ins[15:0]};
                `OP_SLTI: res = {31'b0, $signed(a) < $signed(imm_s)};
                `OP_BEQ:
                begin
                    // Target relative to the next word
                    wr = 1'b0;
                    if (a == b)
                    begin
                        next_pc = pc + 4 + (imm_s << 2);
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && (dst != '0))
            begin
                model_regs[dst] = res;
            end
            pc = next_pc;
        end
        return pc;
    endfunction

    // Comparing process, registers then PC then STATUS
    always
    begin
        @(check_start);
        for (int r = 0; r < `NUM_REGS; r++)
        begin
            apb_read(`ADDR_REG_BASE + `APB_AW'(4 * r), cmp_word);
            check_word(cmp_word, model_regs[r], $sformatf("register r%0d", r));
        end
        apb_read(`ADDR_PC, cmp_word);
        check_word(cmp_word, exp_pc, "PC");
        apb_read(`ADDR_STATUS, cmp_word);
        check_word(cmp_word, exp_status, "STATUS");
        -> check_done;
    end

    //////////////////////////////////////////////////////////////////////
    // Program handling
    //////////////////////////////////////////////////////////////////////

    task automatic request_compare();
        -> check_start;
        @(check_done);
    endtask

    task automatic clear_program();
        for (int i = 0; i < `IMEM_WORDS; i++)
        begin
            prog[i] = `HALT_WORD;
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < `IMEM_WORDS; i++)
        begin
            apb_write(imem_byte_addr(i), prog[i], 1'b0);
        end
    endtask

    // Poll STATUS until halted
    task automatic wait_halt();
        word_t st;
        st = '0;
        while (!st[1])
        begin
            apb_read(`ADDR_STATUS, st);
        end
    endtask

    task automatic run_program();
        load_program();
        exp_pc     = run_reference();
        exp_status = 32'd2;
        apb_write(`ADDR_CTRL, 32'd1, 1'b0);
        wait_halt();
        request_compare();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        apb   = '0;
        rst_n = 1'b0;
        for (int r = 0; r < `NUM_REGS; r++)
        begin
            model_regs[r] = '0;
        end
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        rst_n = 1'b1;

        // Test 1, everything cleared after reset
        exp_pc     = '0;
        exp_status = '0;
        request_compare();

        // Test 2, program window readback
        for (int i = 0; i < `IMEM_WORDS; i++)
        begin
            rnd         = $random(seed);
            wr_words[i] = rnd;
            apb_write(imem_byte_addr(i), rnd, 1'b0);
        end
        for (int i = 0; i < `IMEM_WORDS; i++)
        begin
            apb_read(imem_byte_addr(i), rd_word);
            check_word(rd_word, wr_words[i], $sformatf("program word %0d", i));
        end

        // Test 3, immediates seed r1..r8 then random R-type mix
        clear_program();
        for (int i = 0; i < 8; i++)
        begin
            rnd     = $random(seed);
            prog[i] = enc_i(pick_imm_op(i % 3), rnd[25:21], reg_addr_t'(i + 1), rnd[15:0]);
        end
        for (int i = 8; i < 32; i++)
        begin
            rnd     = $random(seed);
            prog[i] = enc_r(pick_funct(rnd[31:28] % 4'd9), rnd[25:21], rnd[20:16],
                            (i == 20) ? 5'd0 : rnd[15:11], rnd[10:6]);
        end
        run_program();

        // Test 4, countdown from 5 summing into r2
        clear_program();
        prog[0] = enc_i(`OP_ADDI, 5'd0, 5'd1, 16'd5);
        prog[1] = enc_i(`OP_ADDI, 5'd0, 5'd2, 16'd0);
        prog[2] = enc_i(`OP_BEQ, 5'd1, 5'd0, 16'd3);
        prog[3] = enc_r(`FN_ADD, 5'd2, 5'd1, 5'd2, 5'd0);
        prog[4] = enc_i(`OP_ADDI, 5'd1, 5'd1, 16'hFFFF);
        prog[5] = enc_i(`OP_BEQ, 5'd0, 5'd0, 16'hFFFC);
        prog[6] = enc_i(`OP_ORI, 5'd2, 5'd3, 16'h0100);
        run_program();

        // Test 5, host errors while a branch spins on itself
        clear_program();
        prog[0] = enc_i(`OP_BEQ, 5'd0, 5'd0, 16'hFFFF);
        load_program();
        apb_write(`ADDR_CTRL, 32'd1, 1'b0);
        apb_read(`ADDR_STATUS, rd_word);
        check_word(rd_word, 32'd1, "STATUS while running");
        apb_write(`ADDR_IMEM_BASE, 32'h1234_5678, 1'b1);
        apb_read(`ADDR_IMEM_BASE, rd_word);
        check_word(rd_word, prog[0], "program word 0 after refused write");
        apb_access(1'b0, 12'h300, '0, rd_word, rd_err);
        check_word(word_t'(rd_err), 32'd1, "pslverr of unmapped read");
        apb_access(1'b1, 12'h180, 32'hA5A5_A5A5, rd_word, rd_err);
        check_word(word_t'(rd_err), 32'd1, "pslverr of unmapped write");
        // Abort, nothing was written and PC never moved
        apb_write(`ADDR_CTRL, 32'd2, 1'b0);
        exp_pc     = '0;
        exp_status = '0;
        request_compare();

        report_counts();
        if (errors == 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== mips_core.sv ====
`include "mips_core_consts.svh"

module mips_core
    import mips_core_pkg::*;
(
    input  logic     i_clk,
    input  logic     rst_n,
    input  apb_req_t apb,
    output apb_rsp_t apb_rsp
);

    // Fetch path
    imem_addr_t pc_index;
    word_t      instr;

    // Decode and operands
    ctrl_t      ctrl;
    operands_t  operands;

    // Execute results
    logic       alu_we;
    logic       rf_we;
    reg_addr_t  wr_addr;
    word_t      wr_data;
    logic       branch_taken;
    word_t      branch_offset;
    logic       commit;

    // Host side ports
    logic       imem_wr_en;
    imem_addr_t imem_wr_addr;
    word_t      imem_wr_data;
    imem_addr_t imem_host_addr;
    word_t      imem_host_data;
    reg_addr_t  reg_host_addr;
    word_t      reg_host_data;

    // Writes land only on committed RUN cycles
    assign rf_we = alu_we & commit;

    //////////////////////////////////////////////////////////////////////
    // Instances
    //////////////////////////////////////////////////////////////////////

    instr_memory instr_memory_inst
    (
        .i_clk     (i_clk),
        .wr_en     (imem_wr_en),
        .wr_addr   (imem_wr_addr),
        .wr_data   (imem_wr_data),
        .rd_addr   (pc_index),
        .host_addr (imem_host_addr),
        .instr     (instr),
        .host_data (imem_host_data)
    );

    control_decoder control_decoder_inst
    (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // rs and rt straight from the fetched word
    register_file register_file_inst
    (
        .i_clk     (i_clk),
        .rst_n     (rst_n),
        .rs_addr   (instr[25:21]),
        .rt_addr   (instr[20:16]),
        .operands  (operands),
        .host_addr (reg_host_addr),
        .host_data (reg_host_data),
        .we        (rf_we),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    alu_execute alu_execute_inst
    (
        .ctrl          (ctrl),
        .operands      (operands),
        .instr         (instr),
        .we            (alu_we),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .branch_taken  (branch_taken),
        .branch_offset (branch_offset)
    );

    core_control core_control_inst
    (
        .i_clk          (i_clk),
        .rst_n          (rst_n),
        .apb            (apb),
        .apb_rsp        (apb_rsp),
        .pc_index       (pc_index),
        .instr          (instr),
        .branch_taken   (branch_taken),
        .branch_offset  (branch_offset),
        .commit         (commit),
        .imem_wr_en     (imem_wr_en),
        .imem_wr_addr   (imem_wr_addr),
        .imem_wr_data   (imem_wr_data),
        .imem_host_addr (imem_host_addr),
        .imem_host_data (imem_host_data),
        .reg_host_addr  (reg_host_addr),
        .reg_host_data  (reg_host_data)
    );

endmodule

// ==== core_control.sv ====
`include "mips_core_consts.svh"

module core_control
    import mips_core_pkg::*;
(
    input  logic       i_clk,
    input  logic       rst_n,
    input  apb_req_t   apb,
    output apb_rsp_t   apb_rsp,
    output imem_addr_t pc_index,
    input  word_t      instr,
    input  logic       branch_taken,
    input  word_t      branch_offset,
    output logic       commit,
    output logic       imem_wr_en,
    output imem_addr_t imem_wr_addr,
    output word_t      imem_wr_data,
    output imem_addr_t imem_host_addr,
    input  word_t      imem_host_data,
    output reg_addr_t  reg_host_addr,
    input  word_t      reg_host_data
);

    core_state_e        state;
    word_t              pc;
    word_t              pc_plus4;
    logic               access;
    logic [`APB_AW-1:0] imem_off;
    logic [`APB_AW-1:0] reg_off;
    logic               hit_imem;
    logic               hit_reg;
    logic               is_ctrl;
    logic               is_status;
    logic               is_pc;
    logic               mapped;
    logic               imem_busy_wr;
    logic               ctrl_wr;
    logic               halt_fetch;
    word_t              rsp_data;

    //////////////////////////////////////////////////////////////////////
    // APB decode
    //////////////////////////////////////////////////////////////////////

    // Access phase, zero wait
    assign access = apb.psel & apb.penable;

    // Window offsets
    assign imem_off = apb.paddr - `ADDR_IMEM_BASE;
    assign reg_off  = apb.paddr - `ADDR_REG_BASE;

    assign hit_imem  = imem_off < `APB_AW'(4 * `IMEM_WORDS);
    assign hit_reg   = reg_off < `APB_AW'(4 * `NUM_REGS);
    assign is_ctrl   = apb.paddr == `ADDR_CTRL;
    assign is_status = apb.paddr == `ADDR_STATUS;
    assign is_pc     = apb.paddr == `ADDR_PC;
    assign mapped    = hit_imem | hit_reg | is_ctrl | is_status | is_pc;

    // Program load refused while running
    assign imem_busy_wr = apb.pwrite & hit_imem & (state == ST_RUN);

    // Host memory ports, word index from the offset
    assign imem_wr_en     = access & apb.pwrite & hit_imem & (state != ST_RUN);
    assign imem_wr_addr   = imem_off[`IMEM_AW+1:2];
    assign imem_wr_data   = apb.pwdata;
    assign imem_host_addr = imem_off[`IMEM_AW+1:2];
    assign reg_host_addr  = reg_off[`REG_AW+1:2];

    // Read mux, CTRL reads as zero
    always_comb
    begin
        rsp_data = '0;
        if (hit_imem)
        begin
            rsp_data = imem_host_data;
        end
        else if (hit_reg)
        begin
            rsp_data = reg_host_data;
        end
        else if (is_status)
        begin
            rsp_data = word_t'({state == ST_HALTED, state == ST_RUN});
        end
        else if (is_pc)
        begin
            rsp_data = pc;
        end
    end

    assign apb_rsp.prdata  = rsp_data;
    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = access & (!mapped | imem_busy_wr);

    //////////////////////////////////////////////////////////////////////
    // Run control and PC
    //////////////////////////////////////////////////////////////////////

    assign ctrl_wr    = access & apb.pwrite & is_ctrl;
    assign halt_fetch = (state == ST_RUN) && (instr == `HALT_WORD);
    // One instruction retires per RUN cycle
    assign commit     = (state == ST_RUN) && !halt_fetch;
    assign pc_plus4   = pc + 4;
    assign pc_index   = pc[`IMEM_AW+1:2];

    always_ff @(posedge i_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= ST_IDLE;
            pc    <= '0;
        end
        else if (ctrl_wr && apb.pwdata[1])
        begin
            // Abort wins over start
            state <= ST_IDLE;
        end
        else if (ctrl_wr && apb.pwdata[0])
        begin
            state <= ST_RUN;
            pc    <= '0;
        end
        else if (halt_fetch)
        begin
            // PC stays on the halt word
            state <= ST_HALTED;
        end
        else if (commit)
        begin
            pc <= branch_taken ? pc_plus4 + branch_offset : pc_plus4;
        end
    end

    // Access phase only inside a selected transfer
    a_penable_with_psel: assert property (@(posedge i_clk) disable iff (!rst_n)
        apb.penable |-> apb.psel);

endmodule

// ==== alu_execute.sv ====
`include "mips_core_consts.svh"

module alu_execute
    import mips_core_pkg::*;
(
    input  ctrl_t     ctrl,
    input  operands_t operands,
    input  word_t     instr,
    output logic      we,
    output reg_addr_t wr_addr,
    output word_t     wr_data,
    output logic      branch_taken,
    output word_t     branch_offset
);

    reg_addr_t   rt_field;
    reg_addr_t   rd_field;
    logic [4:0]  shamt;
    logic [15:0] imm;
    word_t       imm_sext;
    word_t       imm_zext;
    word_t       op_b;
    word_t       result;

    // Instruction fields
    assign rt_field = instr[20:16];
    assign rd_field = instr[15:11];
    assign shamt    = instr[10:6];
    assign imm      = instr[15:0];

    // Immediate extensions
    assign imm_sext = {{(`NBITS-16){imm[15]}}, imm};
    assign imm_zext = {{(`NBITS-16){1'b0}}, imm};

    // Second operand select
    always_comb
    begin
        if (!ctrl.use_imm)
        begin
            op_b = operands.rt_val;
        end
        else if (ctrl.imm_zero_ext)
        begin
            op_b = imm_zext;
        end
        else
        begin
            op_b = imm_sext;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Operation
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (ctrl.alu_op)
            // ADD and SUB wrap, no overflow trap
            ALU_ADD: result = operands.rs_val + op_b;
            ALU_SUB: result = operands.rs_val - op_b;
            ALU_AND: result = operands.rs_val & op_b;
            ALU_OR:  result = operands.rs_val | op_b;
            ALU_NOR: result = ~(operands.rs_val | op_b);
            ALU_XOR: result = operands.rs_val ^ op_b;
            // Signed compare for SLT and SLTI
            ALU_SLT: result = word_t'($signed(operands.rs_val) < $signed(op_b));
            // Shift source is rt, not rs
            ALU_SLL: result = operands.rt_val << shamt;
            default: result = '0;
        endcase
    end

    // Write back
    assign we      = ctrl.reg_write;
    assign wr_addr = ctrl.dest_is_rd ? rd_field : rt_field;
    assign wr_data = result;

    // BEQ on equal operands, offset in words
    assign branch_taken  = ctrl.is_branch && (operands.rs_val == operands.rt_val);
    assign branch_offset = imm_sext << 2;

endmodule

// ==== register_file.sv ====
`include "mips_core_consts.svh"

module register_file
    import mips_core_pkg::*;
(
    input  logic      i_clk,
    input  logic      rst_n,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    output operands_t operands,
    input  reg_addr_t host_addr,
    output word_t     host_data,
    input  logic      we,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [`NUM_REGS];

    // Write port, r0 stays zero since it is never written
    always_ff @(posedge i_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && (wr_addr != '0))
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Operand read ports
    assign operands.rs_val = regs[rs_addr];
    assign operands.rt_val = regs[rt_addr];

    // Host readback port
    assign host_data = regs[host_addr];

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // A committed write must name a known register
    a_we_addr_known: assert property (@(posedge i_clk) disable iff (!rst_n)
        we |-> !$isunknown(wr_addr));

endmodule

// ==== control_decoder.sv ====
`include "mips_core_consts.svh"

module control_decoder
    import mips_core_pkg::*;
(
    input  word_t instr,
    output ctrl_t ctrl
);

    opcode_t opcode;
    funct_t  funct;

    // Instruction fields
    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb
    begin
        // Default is a no-op, nothing written
        ctrl.alu_op       = ALU_PASS_NONE;
        ctrl.use_imm      = 1'b0;
        ctrl.imm_zero_ext = 1'b0;
        ctrl.reg_write    = 1'b0;
        ctrl.dest_is_rd   = 1'b0;
        ctrl.is_branch    = 1'b0;

        case (opcode)
            `OP_RTYPE:
            begin
                // R-type writes rd, op picked by funct
                ctrl.dest_is_rd = 1'b1;
                ctrl.reg_write  = 1'b1;
                case (funct)
                    `FN_ADD:  ctrl.alu_op = ALU_ADD;
                    `FN_SUB:  ctrl.alu_op = ALU_SUB;
                    // No traps, so SUBU is plain SUB
                    `FN_SUBU: ctrl.alu_op = ALU_SUB;
                    `FN_AND:  ctrl.alu_op = ALU_AND;
                    `FN_OR:   ctrl.alu_op = ALU_OR;
                    `FN_NOR:  ctrl.alu_op = ALU_NOR;
                    `FN_XOR:  ctrl.alu_op = ALU_XOR;
                    `FN_SLT:  ctrl.alu_op = ALU_SLT;
                    `FN_SLL:  ctrl.alu_op = ALU_SLL;
                    default:
                    begin
                        // Unknown funct
                        ctrl.reg_write = 1'b0;
                    end
                endcase
            end
            `OP_ADDI:
            begin
                ctrl.alu_op    = ALU_ADD;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            `OP_ORI:
            begin
                // Logical immediate, zero extended
                ctrl.alu_op       = ALU_OR;
                ctrl.use_imm      = 1'b1;
                ctrl.imm_zero_ext = 1'b1;
                ctrl.reg_write    = 1'b1;
            end
            `OP_SLTI:
            begin
                ctrl.alu_op    = ALU_SLT;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            `OP_BEQ:
            begin
                // Compare rs and rt, nothing written back
                ctrl.alu_op    = ALU_SUB;
                ctrl.is_branch = 1'b1;
            end
            default:
            begin
                // Unsupported opcode, halt word included
                ctrl.alu_op = ALU_PASS_NONE;
            end
        endcase
    end

endmodule

// ==== instr_memory.sv ====
`include "mips_core_consts.svh"

module instr_memory
    import mips_core_pkg::*;
(
    input  logic       i_clk,
    input  logic       wr_en,
    input  imem_addr_t wr_addr,
    input  word_t      wr_data,
    input  imem_addr_t rd_addr,
    input  imem_addr_t host_addr,
    output word_t      instr,
    output word_t      host_data
);

    // Program storage, no reset, contents valid once loaded
    word_t memory [`IMEM_WORDS];

    // Host load port, one word per access edge
    always_ff @(posedge i_clk)
    begin
        if (wr_en)
        begin
            memory[wr_addr] <= wr_data;
        end
    end

    // Fetch port at the PC word index
    assign instr     = memory[rd_addr];
    // Host readback port
    assign host_data = memory[host_addr];

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // A load must always hit a known word
    a_wr_addr_known: assert property (@(posedge i_clk)
        wr_en |-> !$isunknown(wr_addr));

endmodule

// ==== mips_core_pkg.sv ====
`include "mips_core_consts.svh"

package mips_core_pkg;

    // Widths with a meaning
    typedef logic [`NBITS-1:0]   word_t;
    typedef logic [`REG_AW-1:0]  reg_addr_t;
    typedef logic [`IMEM_AW-1:0] imem_addr_t;
    typedef logic [5:0]          opcode_t;
    typedef logic [5:0]          funct_t;

    // ALU operations, PASS_NONE for anything not decoded
    typedef enum logic [3:0]
    {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_NOR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_PASS_NONE
    } alu_op_e;

    // Run control of the core
    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_RUN,
        ST_HALTED
    } core_state_e;

    // Decoded control word
    typedef struct packed
    {
        alu_op_e alu_op;
        logic    use_imm;
        logic    imm_zero_ext;  // ORI only
        logic    reg_write;
        logic    dest_is_rd;
        logic    is_branch;
    } ctrl_t;

    // Register file read values
    typedef struct packed
    {
        word_t rs_val;
        word_t rt_val;
    } operands_t;

    // APB request from the host
    typedef struct packed
    {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [`APB_AW-1:0] paddr;
        word_t             pwdata;
    } apb_req_t;

    // APB response back to the host
    typedef struct packed
    {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

endpackage

// ==== mips_core_consts.svh ====
`ifndef MIPS_CORE_CONSTS_SVH
`define MIPS_CORE_CONSTS_SVH

// Datapath and storage sizes
`define NBITS       32
`define IMEM_WORDS  64
`define IMEM_AW     6
`define NUM_REGS    32
`define REG_AW      5
`define APB_AW      12

// Fetching this word stops the core
`define HALT_WORD   32'hFFFF_FFFF

// Primary opcodes
`define OP_RTYPE    6'b000000
`define OP_ADDI     6'b001000
`define OP_ORI      6'b001101
`define OP_SLTI     6'b001010
`define OP_BEQ      6'b000100

// Funct field of the R-type group
`define FN_ADD      6'b100000
`define FN_SUB      6'b100010
`define FN_SUBU     6'b100011
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_NOR      6'b100111
`define FN_XOR      6'b100110
`define FN_SLT      6'b101010
`define FN_SLL      6'b000000

// Host address map, byte addresses
`define ADDR_IMEM_BASE  12'h000
`define ADDR_REG_BASE   12'h100
`define ADDR_CTRL       12'h200
`define ADDR_STATUS     12'h204
`define ADDR_PC         12'h208

`endif
